//--- Makefile
VERILATOR   ?= verilator
TOP         := ppu_pixel_out_tb
RTL_TOP     := ppu_pixel_out
FILE_LIST   := list.f
BUILD_FLAGS := --binary --timing -Wno-fatal -j 0
LINT_FLAGS  := --lint-only --timing -Wall
BUILD_DIR   := obj_dir
SIM_BIN     := $(BUILD_DIR)/V$(TOP)
LOG         := sim.log
PASS_MSG    := Simulation finished: PASS
SOURCES     := $(wildcard logic/*.sv logic/*.svh verif/*.sv)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
+incdir+logic
logic/ppu_pixel_pkg.sv
logic/ppu_bus_pkg.sv
logic/pixel_fifo.sv
logic/frame_ram.sv
logic/ppu_reg_block.sv
logic/framebuffer.sv
logic/ppu_pixel_out.sv
verif/ppu_pixel_out_tb.sv

//--- logic/frame_ram.sv
`timescale 1ns/1ps

`include "ppu_consts.svh"

module frame_ram
  import ppu_pixel_pkg::*;
(
  input  logic      clk,
  input  fb_write_t fb_write,
  input  fb_addr_t  rd_addr,
  output shade_t    rd_shade
);

  localparam int NUM_PIXELS = `PPU_SCREEN_WIDTH * `PPU_SCREEN_HEIGHT;

  // One shade per visible pixel, row after row
  shade_t mem [NUM_PIXELS];

  always_ff @(posedge clk) begin
    if (fb_write.en) begin
      mem[fb_write.addr] <= fb_write.shade;
    end
  end

  // Registered read port for the host side
  always_ff @(posedge clk) begin
    rd_shade <= mem[rd_addr];
  end

endmodule

//--- logic/framebuffer.sv
`timescale 1ns/1ps

`include "ppu_consts.svh"

module framebuffer
  import ppu_pixel_pkg::*;
  import ppu_bus_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          pixel_transfer_en,
  input  logic          stall,
  input  logic          flush,
  input  ppu_regs_t     regs,
  input  logic          bg_empty,
  input  bg_entry_t     bg_head,
  output logic          bg_pop,
  input  logic          obj_empty,
  input  obj_entry_t    obj_head,
  output logic          obj_pop,
  output fb_write_t     fb_write,
  output screen_coord_t pixel_x,
  output logic          line_done,
  output logic          frame_done
);

  screen_coord_t x_screen;
  screen_coord_t y_screen;
  logic [2:0]    discard_count;
  logic          consume;
  logic          store;
  logic          obj_wins;
  color_id_t     bg_color;
  color_id_t     obj_color;
  shade_t        bg_shade;
  shade_t        obj_shade;

  // Shade lives at bits 2*id+1 : 2*id of the palette byte
  function automatic shade_t map_palette(color_id_t id, logic [7:0] palette);
    return palette[{id, 1'b0} +: 2];
  endfunction

  // Flush has the cycle to itself, no pixel leaves the FIFOs then
  assign consume = pixel_transfer_en && !bg_empty && !stall && !flush;
  assign store   = consume && (discard_count == 3'd0);

  assign bg_pop  = consume;
  assign obj_pop = consume && !obj_empty;

  // LCDC bit 0 blanks the background, bit 1 hides objects
  assign bg_color  = regs.lcdc[0] ? bg_head.color : color_id_t'(0);
  assign obj_color = regs.lcdc[1] ? obj_head.color : color_id_t'(0);

  assign bg_shade  = map_palette(bg_color, regs.bgp);
  assign obj_shade = map_palette(obj_color, obj_head.dmg_palette ? regs.obp1 : regs.obp0);

  assign obj_wins = !obj_empty && (obj_color != color_id_t'(0)) &&
                    (!obj_head.bg_prio || (bg_color == color_id_t'(0)));

  assign fb_write.en    = store;
  assign fb_write.addr  = fb_addr_t'(y_screen) * fb_addr_t'(`PPU_SCREEN_WIDTH) +
                          fb_addr_t'(x_screen);
  assign fb_write.shade = obj_wins ? obj_shade : bg_shade;

  assign pixel_x = x_screen;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      x_screen      <= '0;
      y_screen      <= '0;
      discard_count <= '0;
      line_done     <= 1'b0;
      frame_done    <= 1'b0;
    end else begin
      line_done  <= 1'b0;
      frame_done <= 1'b0;
      if (flush) begin
        x_screen      <= '0;
        // Fine scroll, only SCX mod 8 pixels get dropped
        discard_count <= regs.scx[2:0];
      end else if (consume) begin
        if (discard_count != 3'd0) begin
          discard_count <= discard_count - 3'd1;
        end else if (x_screen == screen_coord_t'(`PPU_SCREEN_WIDTH - 1)) begin
          x_screen  <= '0;
          line_done <= 1'b1;
          if (y_screen == screen_coord_t'(`PPU_SCREEN_HEIGHT - 1)) begin
            y_screen   <= '0;
            frame_done <= 1'b1;
          end else begin
            y_screen <= y_screen + 1'b1;
          end
        end else begin
          x_screen <= x_screen + 1'b1;
        end
      end
    end
  end

endmodule

//--- logic/pixel_fifo.sv
`timescale 1ns/1ps

`include "ppu_consts.svh"

module pixel_fifo #(
  parameter type entry_t = logic [1:0],
  parameter int  DEPTH   = `PPU_FIFO_DEPTH
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   push,
  input  entry_t push_data,
  input  logic   pop,
  output entry_t head,
  output logic   empty,
  output logic   full
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  entry_t mem [DEPTH];

  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));

  // A full FIFO still takes a push when the head leaves in the same cycle
  assign do_pop  = pop && !empty;
  assign do_push = push && (!full || do_pop);

  assign head = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- logic/ppu_bus_pkg.sv
`include "ppu_consts.svh"

package ppu_bus_pkg;

  typedef logic [`PPU_WB_ADDR_W-1:0] wb_addr_t;
  typedef logic [`PPU_WB_DATA_W-1:0] wb_data_t;

  // Master to slave half of a Wishbone classic cycle
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat_w;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    wb_data_t dat_r;
  } wb_rsp_t;

  // Rendering registers seen by the pixel path
  typedef struct packed {
    logic [7:0] lcdc;
    logic [7:0] scx;
    logic [7:0] bgp;
    logic [7:0] obp0;
    logic [7:0] obp1;
  } ppu_regs_t;

  // Register offsets relative to the register base
  typedef enum wb_addr_t {
    REG_LCDC = 16'h0000,
    REG_SCX  = 16'h0001,
    REG_BGP  = 16'h0002,
    REG_OBP0 = 16'h0003,
    REG_OBP1 = 16'h0004
  } reg_addr_e;

endpackage

//--- logic/ppu_consts.svh
`ifndef PPU_CONSTS_SVH
`define PPU_CONSTS_SVH

// Visible screen area in pixels
`define PPU_SCREEN_WIDTH  160
`define PPU_SCREEN_HEIGHT 144

// Entries per pixel FIFO
`define PPU_FIFO_DEPTH 16

// Frame memory index width, enough for 160 x 144 entries
`define PPU_FB_ADDR_W 15

// Host bus widths
`define PPU_WB_ADDR_W 16
`define PPU_WB_DATA_W 8

// Bus addresses from here up hit the register file,
// everything below reads frame memory
`define PPU_REG_BASE 16'h8000

`endif

//--- logic/ppu_pixel_out.sv
`timescale 1ns/1ps

module ppu_pixel_out
  import ppu_pixel_pkg::*;
  import ppu_bus_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  wb_req_t       wb_req,
  output wb_rsp_t       wb_rsp,
  input  logic          pixel_transfer_en,
  input  logic          stall,
  input  logic          flush,
  input  logic          bg_push,
  input  bg_entry_t     bg_push_data,
  output logic          bg_full,
  input  logic          obj_push,
  input  obj_entry_t    obj_push_data,
  output logic          obj_full,
  output screen_coord_t pixel_x,
  output logic          line_done,
  output logic          frame_done
);

  ppu_regs_t  regs;
  logic       bg_empty;
  logic       bg_pop;
  bg_entry_t  bg_head;
  logic       obj_empty;
  logic       obj_pop;
  obj_entry_t obj_head;
  fb_write_t  fb_write;
  fb_addr_t   fb_rd_addr;
  shade_t     fb_rd_shade;

  pixel_fifo #(
    .entry_t (bg_entry_t)
  ) bg_fifo_inst (
    .clk       (clk),
    .reset     (reset),
    .push      (bg_push),
    .push_data (bg_push_data),
    .pop       (bg_pop),
    .head      (bg_head),
    .empty     (bg_empty),
    .full      (bg_full)
  );

  pixel_fifo #(
    .entry_t (obj_entry_t)
  ) obj_fifo_inst (
    .clk       (clk),
    .reset     (reset),
    .push      (obj_push),
    .push_data (obj_push_data),
    .pop       (obj_pop),
    .head      (obj_head),
    .empty     (obj_empty),
    .full      (obj_full)
  );

  ppu_reg_block ppu_reg_block_inst (
    .clk         (clk),
    .reset       (reset),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .regs        (regs),
    .fb_rd_addr  (fb_rd_addr),
    .fb_rd_shade (fb_rd_shade)
  );

  framebuffer framebuffer_inst (
    .clk               (clk),
    .reset             (reset),
    .pixel_transfer_en (pixel_transfer_en),
    .stall             (stall),
    .flush             (flush),
    .regs              (regs),
    .bg_empty          (bg_empty),
    .bg_head           (bg_head),
    .bg_pop            (bg_pop),
    .obj_empty         (obj_empty),
    .obj_head          (obj_head),
    .obj_pop           (obj_pop),
    .fb_write          (fb_write),
    .pixel_x           (pixel_x),
    .line_done         (line_done),
    .frame_done        (frame_done)
  );

  frame_ram frame_ram_inst (
    .clk      (clk),
    .fb_write (fb_write),
    .rd_addr  (fb_rd_addr),
    .rd_shade (fb_rd_shade)
  );

endmodule

//--- logic/ppu_pixel_pkg.sv
`include "ppu_consts.svh"

package ppu_pixel_pkg;

  // Color index as it comes out of the fetcher, before any palette
  typedef logic [1:0] color_id_t;

  // Shade after palette mapping, 0 is lightest
  typedef logic [1:0] shade_t;

  // Linear frame memory index, y * width + x
  typedef logic [`PPU_FB_ADDR_W-1:0] fb_addr_t;

  typedef logic [7:0] screen_coord_t;

  typedef struct packed {
    color_id_t color;
  } bg_entry_t;

  typedef struct packed {
    color_id_t color;
    logic      dmg_palette;  // 0 picks OBP0, 1 picks OBP1
    logic      bg_prio;      // 1 hides behind non-zero background
  } obj_entry_t;

  typedef struct packed {
    logic     en;
    fb_addr_t addr;
    shade_t   shade;
  } fb_write_t;

endpackage

//--- logic/ppu_reg_block.sv
`timescale 1ns/1ps

`include "ppu_consts.svh"

module ppu_reg_block
  import ppu_pixel_pkg::*;
  import ppu_bus_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  wb_req_t   wb_req,
  output wb_rsp_t   wb_rsp,
  output ppu_regs_t regs,
  output fb_addr_t  fb_rd_addr,
  input  shade_t    fb_rd_shade
);

  logic     ack;
  logic     access;
  logic     is_reg;
  wb_addr_t reg_off;
  wb_data_t reg_rdata;

  // First cycle of a cycle/strobe pair, ack is high on the second
  assign access = wb_req.cyc && wb_req.stb && !ack;

  assign is_reg  = (wb_req.adr >= wb_addr_t'(`PPU_REG_BASE));
  assign reg_off = wb_req.adr - wb_addr_t'(`PPU_REG_BASE);

  // Frame memory sees the address straight away, its registered
  // output then lines up with the ack cycle
  assign fb_rd_addr = wb_req.adr[`PPU_FB_ADDR_W-1:0];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ack <= 1'b0;
    end else begin
      ack <= access;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs <= '0;
    end else if (access && wb_req.we && is_reg) begin
      case (reg_off)
        REG_LCDC: regs.lcdc <= wb_req.dat_w;
        REG_SCX:  regs.scx  <= wb_req.dat_w;
        REG_BGP:  regs.bgp  <= wb_req.dat_w;
        REG_OBP0: regs.obp0 <= wb_req.dat_w;
        REG_OBP1: regs.obp1 <= wb_req.dat_w;
        default: ;
      endcase
    end
  end

  // Unused offsets read as zero
  always_comb begin
    case (reg_off)
      REG_LCDC: reg_rdata = regs.lcdc;
      REG_SCX:  reg_rdata = regs.scx;
      REG_BGP:  reg_rdata = regs.bgp;
      REG_OBP0: reg_rdata = regs.obp0;
      REG_OBP1: reg_rdata = regs.obp1;
      default:  reg_rdata = '0;
    endcase
  end

  assign wb_rsp.ack   = ack;
  assign wb_rsp.dat_r = is_reg ? reg_rdata : wb_data_t'(fb_rd_shade);

endmodule

//--- verif/ppu_pixel_out_tb.sv
`timescale 1ns/1ps

`include "ppu_consts.svh"

module ppu_pixel_out_tb
  import ppu_pixel_pkg::*;
  import ppu_bus_pkg::*;
();

  localparam string DATA_FILE = "verif/ppu_pixel_out_testdata.txt";

  // One stimulus file line as a command letter and up to five hex fields
  typedef struct packed {
    logic [7:0]       cmd;
    logic [4:0][31:0] arg;
  } record_t;

  logic          clk;
  logic          reset;
  wb_req_t       wb_req;
  wb_rsp_t       wb_rsp;
  logic          pixel_transfer_en;
  logic          stall;
  logic          flush;
  logic          bg_push;
  bg_entry_t     bg_push_data;
  logic          bg_full;
  logic          obj_push;
  obj_entry_t    obj_push_data;
  logic          obj_full;
  screen_coord_t pixel_x;
  logic          line_done;
  logic          frame_done;

  record_t     records[$];
  logic [31:0] lfsr = 32'hb254ab41;
  int unsigned cycle_count = 0;
  int unsigned cycle_limit = 0;
  int unsigned line_count = 0;
  int unsigned frame_count = 0;

  ppu_pixel_out ppu_pixel_out_inst (
    .clk               (clk),
    .reset             (reset),
    .wb_req            (wb_req),
    .wb_rsp            (wb_rsp),
    .pixel_transfer_en (pixel_transfer_en),
    .stall             (stall),
    .flush             (flush),
    .bg_push           (bg_push),
    .bg_push_data      (bg_push_data),
    .bg_full           (bg_full),
    .obj_push          (obj_push),
    .obj_push_data     (obj_push_data),
    .obj_full          (obj_full),
    .pixel_x           (pixel_x),
    .line_done         (line_done),
    .frame_done        (frame_done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      abort_run();
    end
  endtask

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  task automatic next_random_bit(output logic value);
    value = lfsr[0];
    lfsr = lfsr_step(lfsr);
  endtask

  // One Wishbone classic cycle held until ack
  task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t dat_w,
                            output wb_data_t dat_r);
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    wb_req = wb_req_t'{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: dat_w};
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_rsp.ack);
    dat_r = wb_rsp.dat_r;
    wb_req = '0;
    check_value("wb ack latency", waited, 32'd1);
  endtask

  task automatic push_bg(input int unsigned count, input color_id_t color,
                         input logic exp_full);
    repeat (count) begin
      @(negedge clk);
      bg_push = 1'b1;
      bg_push_data.color = color;
    end
    @(negedge clk);
    bg_push = 1'b0;
    check_value("bg_full", 32'(bg_full), 32'(exp_full));
  endtask

  task automatic push_obj(input int unsigned count, input obj_entry_t entry,
                          input logic exp_full);
    repeat (count) begin
      @(negedge clk);
      obj_push = 1'b1;
      obj_push_data = entry;
    end
    @(negedge clk);
    obj_push = 1'b0;
    check_value("obj_full", 32'(obj_full), 32'(exp_full));
  endtask

  task automatic flush_line();
    @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
  endtask

  // Transfer runs until the DUT reports both FIFOs empty
  task automatic drain_fifos(input screen_coord_t exp_x);
    @(negedge clk);
    pixel_transfer_en = 1'b1;
    do begin
      @(negedge clk);
    end while (!(ppu_pixel_out_inst.bg_empty && ppu_pixel_out_inst.obj_empty));
    pixel_transfer_en = 1'b0;
    check_value("pixel_x", 32'(pixel_x), 32'(exp_x));
  endtask

  task automatic hold_transfer(input int unsigned cycles, input logic stall_on,
                               input screen_coord_t exp_x, input logic exp_full);
    @(negedge clk);
    pixel_transfer_en = 1'b1;
    stall = stall_on;
    repeat (cycles) begin
      @(negedge clk);
      check_value("pixel_x", 32'(pixel_x), 32'(exp_x));
      check_value("bg_full", 32'(bg_full), 32'(exp_full));
    end
    pixel_transfer_en = 1'b0;
    stall = 1'b0;
  endtask

  // Streams random background pixels while transfer is on
  // The pixel count ends the fill on a line boundary
  task automatic fill_frame(input int unsigned pixels, input int unsigned exp_lines,
                            input int unsigned exp_frames);
    int unsigned pushed;
    int unsigned lines_before;
    int unsigned frames_before;
    logic        bit_hi;
    logic        bit_lo;
    pushed = 0;
    lines_before = line_count;
    frames_before = frame_count;
    while (pushed < pixels) begin
      @(negedge clk);
      pixel_transfer_en = 1'b1;
      bg_push = 1'b0;
      if (!bg_full) begin
        next_random_bit(bit_hi);
        next_random_bit(bit_lo);
        bg_push = 1'b1;
        bg_push_data.color = {bit_hi, bit_lo};
        pushed++;
      end
    end
    @(negedge clk);
    bg_push = 1'b0;
    drain_fifos(8'd0);
    @(negedge clk);
    check_value("line_done pulses", line_count - lines_before, exp_lines);
    check_value("frame_done pulses", frame_count - frames_before, exp_frames);
  endtask

  task automatic load_records(output int unsigned fill_pixels);
    int          fd;
    string       line;
    record_t     rec;
    logic [31:0] v [5];
    fill_pixels = 0;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file %s", DATA_FILE);
      abort_run();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      foreach (v[i]) begin
        v[i] = '0;
      end
      void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4]));
      rec.cmd = line[0];
      foreach (v[i]) begin
        rec.arg[i] = v[i];
      end
      records.push_back(rec);
      if (line[0] == "L") begin
        fill_pixels += v[0];
      end
    end
    $fclose(fd);
  endtask

  task automatic run_record(input record_t rec);
    wb_data_t   rdata;
    obj_entry_t entry;
    case (rec.cmd)
      "W": bus_access(1'b1, wb_addr_t'(rec.arg[0]), wb_data_t'(rec.arg[1]), rdata);
      "R": begin
        bus_access(1'b0, wb_addr_t'(rec.arg[0]), '0, rdata);
        check_value($sformatf("wb dat_r at 0x%04h", rec.arg[0][15:0]), 32'(rdata), rec.arg[1]);
      end
      "B": push_bg(rec.arg[0], color_id_t'(rec.arg[1]), rec.arg[2][0]);
      "O": begin
        entry.color       = color_id_t'(rec.arg[1]);
        entry.dmg_palette = rec.arg[2][0];
        entry.bg_prio     = rec.arg[3][0];
        push_obj(rec.arg[0], entry, rec.arg[4][0]);
      end
      "F": flush_line();
      "G": drain_fifos(screen_coord_t'(rec.arg[0]));
      "S": hold_transfer(rec.arg[0], rec.arg[1][0], screen_coord_t'(rec.arg[2]), rec.arg[3][0]);
      "L": fill_frame(rec.arg[0], rec.arg[1], rec.arg[2]);
      default: begin
        $display("Unknown record type %c in the stimulus file", rec.cmd);
        abort_run();
      end
    endcase
  endtask

  // Counts line and frame pulses at the falling edge
  always @(negedge clk) begin
    if (reset === 1'b0) begin
      if (line_done) begin
        line_count++;
      end
      if (frame_done) begin
        frame_count++;
        check_value("line_done with frame_done", 32'(line_done), 32'd1);
        check_value("line_done count at frame_done", line_count,
                    frame_count * `PPU_SCREEN_HEIGHT);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("Timeout after %0d clock cycles without finishing the tests", cycle_limit);
      abort_run();
    end
  end

  initial begin
    int unsigned fill_pixels;
    reset = 1'b1;
    wb_req = '0;
    pixel_transfer_en = 1'b0;
    stall = 1'b0;
    flush = 1'b0;
    bg_push = 1'b0;
    bg_push_data = '0;
    obj_push = 1'b0;
    obj_push_data = '0;
    load_records(fill_pixels);
    cycle_limit = records.size() * 8 + fill_pixels * 4 + 1000;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_value("{ack, line_done, frame_done, bg_full, obj_full} after reset",
                32'({wb_rsp.ack, line_done, frame_done, bg_full, obj_full}), 32'd0);
    check_value("pixel_x after reset", 32'(pixel_x), 32'd0);
    foreach (records[i]) begin
      run_record(records[i]);
    end
    repeat (2) @(negedge clk);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- verif/ppu_pixel_out_testdata.txt
# W adr data | R adr expect | B count color full | O count color pal prio full | F | G x
# S cycles stall x full | L pixels lines frames   (all fields hex)
R 8000 00
W 8000 93
R 8000 93
W 8001 5d
R 8001 5d
W 8002 1b
R 8002 1b
W 8003 d2
R 8003 d2
W 8004 78
R 8004 78
R 8005 00
R 80ff 00
B 01 0 0
B 01 1 0
B 01 2 0
B 01 3 0
G 04
R 0000 03
R 0001 02
R 0002 01
R 0003 00
W 8000 92
B 01 3 0
G 05
R 0004 03
W 8000 93
B 01 0 0
B 01 0 0
B 01 2 0
B 01 1 0
B 01 0 0
O 01 1 0 0 0
O 01 1 1 0 0
O 01 0 0 0 0
O 01 3 0 1 0
O 01 3 1 1 0
G 0a
R 0005 00
R 0006 02
R 0007 01
R 0008 02
R 0009 01
W 8000 91
B 01 0 0
O 01 2 0 0 0
G 0b
R 000a 03
W 8000 93
F
B 05 0 0
G 00
B 01 2 0
G 01
R 0000 01
R 0001 02
B 0f 1 0
B 01 1 1
B 01 2 1
S 04 1 01 1
G 11
R 0010 02
S 03 0 11 0
L 59ef 90 1
B 01 3 0
G 01
R 0000 00
